//--- pdp8_ac_pkg.sv
// word and phase types, major opcodes, EAE instruction codes and step count
package pdp8_ac_pkg;

    localparam int word_w = 12;

    // bit 0 is the most significant bit, as in the machine manuals
    typedef logic [0:word_w-1] word_t;

    typedef enum logic [2:0]
    {
        ph_idle = 3'd0,
        ph_f1   = 3'd1,  // clear, complement, mq moves
        ph_f2   = 3'd2,  // increment
        ph_f3   = 3'd3,  // rotates and byte swap
        ph_e2   = 3'd4,  // and / tad
        ph_e3   = 3'd5,  // dca
        ph_eae0 = 3'd6,  // eae setup
        ph_eae1 = 3'd7   // eae iteration
    } phase_t;

    localparam logic [2:0] op_and = 3'd0;
    localparam logic [2:0] op_tad = 3'd1;
    localparam logic [2:0] op_dca = 3'd3;
    localparam logic [2:0] op_opr = 3'd7;

    // eae codes are compared after masking out the mq micro-op bits
    localparam word_t eae_mask     = 12'o7417;
    localparam word_t eae_mul_code = 12'o7405;
    localparam word_t eae_div_code = 12'o7407;

    localparam logic [4:0] eae_steps = 5'd12;  // one step per word bit

endpackage

//--- ac_phase_seq.sv
// phase sequencer stepping one instruction through its phases, with busy and done
`timescale 1ns/1ps

module ac_phase_seq (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clear,
    input  logic                start,
    input  pdp8_ac_pkg::word_t  instruction,
    input  logic                eae_loop,
    output pdp8_ac_pkg::phase_t phase,
    output logic                busy,
    output logic                done
);
    import pdp8_ac_pkg::*;

    phase_t first_phase;  // entry phase of the new instruction
    word_t  eae_code;
    logic   accept;
    logic   is_eae;
    logic   is_opr;
    logic   is_mem;

    assign busy     = (phase != ph_idle) || done;
    assign accept   = start && !busy;
    assign eae_code = instruction & eae_mask;
    assign is_eae   = (eae_code == eae_mul_code) || (eae_code == eae_div_code);
    // group 1, or group 3 with its bit 11 set
    assign is_opr   = (instruction[0:2] == op_opr) && (!instruction[3] || instruction[11]);
    assign is_mem   = instruction[0:2] inside {op_and, op_tad, op_dca};

    always_comb
    begin
        if (is_eae)
            first_phase = ph_eae0;  // checked first, mul/div also look like group 3
        else if (is_opr)
            first_phase = ph_f1;
        else if (is_mem)
            first_phase = ph_e2;
        else
            first_phase = ph_idle;  // completes with nothing changed
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase <= ph_idle;
            done  <= 1'b0;
        end
        else if (clear)
        begin
            phase <= ph_idle;  // aborts without done
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (phase)
                ph_idle:
                    if (accept)
                    begin
                        phase <= first_phase;
                        done  <= (first_phase == ph_idle);
                    end
                ph_f1: phase <= ph_f2;
                ph_f2: phase <= ph_f3;
                ph_e2: phase <= ph_e3;
                ph_f3, ph_e3:
                begin
                    phase <= ph_idle;
                    done  <= 1'b1;
                end
                ph_eae0, ph_eae1:
                    if (eae_loop)
                        phase <= ph_eae1;  // another mul/div step follows
                    else
                    begin
                        phase <= ph_idle;
                        done  <= 1'b1;
                    end
                default: phase <= ph_idle;
            endcase
        end
    end

endmodule

//--- ac_alu.sv
// next link/ac/mq values for the operate and memory reference phases
`timescale 1ns/1ps

module ac_alu (
    input  pdp8_ac_pkg::phase_t phase,
    input  pdp8_ac_pkg::word_t  instruction,
    input  pdp8_ac_pkg::word_t  operand,
    input  pdp8_ac_pkg::word_t  ac,
    input  pdp8_ac_pkg::word_t  mq,
    input  logic                link,
    output logic                alu_link,
    output pdp8_ac_pkg::word_t  alu_ac,
    output pdp8_ac_pkg::word_t  alu_mq
);
    import pdp8_ac_pkg::*;

    logic            grp1;
    logic            grp3;
    logic            link_cll;  // link after cll
    word_t           ac_cla;    // ac after cla
    logic [0:word_w] inc_sum;
    logic [0:word_w] tad_sum;

    assign grp1     = (instruction[0:2] == op_opr) && !instruction[3];
    assign grp3     = (instruction[0:2] == op_opr) && instruction[3] && instruction[11];
    assign ac_cla   = instruction[4] ? '0 : ac;  // cla sits in bit 4 in both groups
    assign link_cll = instruction[5] ? 1'b0 : link;
    assign inc_sum  = {link, ac} + 1'b1;  // carry out of ac flips the link
    assign tad_sum  = {link, ac} + {1'b0, operand};

    always_comb
    begin
        alu_link = link;
        alu_ac   = ac;
        alu_mq   = mq;
        case (phase)
            ph_f1:
                if (grp1)
                begin
                    alu_ac   = instruction[6] ? ~ac_cla : ac_cla;      // cma
                    alu_link = instruction[7] ? ~link_cll : link_cll;  // cml
                end
                else if (grp3)
                begin
                    // mqa and mql act together, which gives swp and cam
                    alu_ac = (instruction[5] ? mq : '0) | (instruction[7] ? '0 : ac_cla);
                    alu_mq = instruction[7] ? ac_cla : mq;
                end
            ph_f2:
                if (grp1 && instruction[11])
                    {alu_link, alu_ac} = inc_sum;  // iac
            ph_f3:
                if (grp1)
                begin
                    case (instruction[8:10])
                        3'b001: alu_ac = {ac[6:11], ac[0:5]};  // bsw
                        3'b010:
                        begin
                            alu_ac   = {ac[1:11], link};  // ral
                            alu_link = ac[0];
                        end
                        3'b011:
                        begin
                            alu_ac   = {ac[2:11], link, ac[0]};  // rtl
                            alu_link = ac[1];
                        end
                        3'b100:
                        begin
                            alu_ac   = {link, ac[0:10]};  // rar
                            alu_link = ac[11];
                        end
                        3'b101:
                        begin
                            alu_ac   = {ac[11], link, ac[0:9]};  // rtr
                            alu_link = ac[10];
                        end
                        default: ;  // no rotate, or a combination with no effect
                    endcase
                end
            ph_e2:
                if (instruction[0:2] == op_and)
                    alu_ac = ac & operand;
                else if (instruction[0:2] == op_tad)
                    {alu_link, alu_ac} = tad_sum;
            ph_e3:
                if (instruction[0:2] == op_dca)
                    alu_ac = '0;  // ac went out with the store
            default: ;
        endcase
    end

endmodule

//--- ac_eae_muldiv.sv
// eae mode A multiply and divide step engine with step counter and loop flag
`timescale 1ns/1ps

module ac_eae_muldiv (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clear,
    input  pdp8_ac_pkg::phase_t phase,
    input  pdp8_ac_pkg::word_t  instruction,
    input  pdp8_ac_pkg::word_t  operand,
    input  pdp8_ac_pkg::word_t  ac,
    input  pdp8_ac_pkg::word_t  mq,
    input  logic                link,
    output logic                eae_loop,
    output logic                eae_link,
    output pdp8_ac_pkg::word_t  eae_ac,
    output pdp8_ac_pkg::word_t  eae_mq
);
    import pdp8_ac_pkg::*;

    logic              is_mul;
    logic              is_div;
    logic              div_ovf;
    logic              setup_loop;
    word_t             mul_addend;
    logic [0:word_w]   mul_sum;   // carry then ac
    logic [0:word_w+1] div_diff;  // bit 0 is the borrow
    logic [4:0]        step_cnt;  // steps still to run
    logic              loop_q;

    assign is_mul     = (instruction & eae_mask) == eae_mul_code;
    assign is_div     = (instruction & eae_mask) == eae_div_code;
    assign div_ovf    = ac >= operand;  // quotient would not fit in mq
    assign setup_loop = is_mul || (is_div && !div_ovf);

    // in setup the sequencer needs the decision before the flag is stored
    assign eae_loop = (phase == ph_eae0) ? setup_loop : loop_q;

    assign mul_addend = mq[word_w-1] ? operand : '0;
    assign mul_sum    = {1'b0, ac} + {1'b0, mul_addend};
    assign div_diff   = {1'b0, ac, mq[0]} - {2'b00, operand};

    always_comb
    begin
        eae_link = link;
        eae_ac   = ac;
        eae_mq   = mq;
        case (phase)
            ph_eae0:
                if (is_mul)
                    eae_link = 1'b0;
                else if (is_div)
                    eae_link = div_ovf;  // overflow flag, registers otherwise kept
            ph_eae1:
                if (is_mul)
                    {eae_ac, eae_mq} = {mul_sum, mq[0:word_w-2]};  // add then shift right
                else if (is_div)
                begin
                    if (!div_diff[0])
                    begin
                        eae_ac = div_diff[2:word_w+1];  // subtract fits
                        eae_mq = {mq[1:word_w-1], 1'b1};
                    end
                    else
                    begin
                        eae_ac = {ac[1:word_w-1], mq[0]};  // restore, shift only
                        eae_mq = {mq[1:word_w-1], 1'b0};
                    end
                end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            step_cnt <= '0;
            loop_q   <= 1'b0;
        end
        else if (clear)
        begin
            step_cnt <= '0;
            loop_q   <= 1'b0;
        end
        else if (phase == ph_eae0)
        begin
            step_cnt <= setup_loop ? eae_steps : '0;
            loop_q   <= setup_loop;
        end
        else if (phase == ph_eae1)
        begin
            step_cnt <= step_cnt - 5'd1;
            loop_q   <= (step_cnt > 5'd2);  // low during the last step
        end
    end

endmodule

//--- ac_regs.sv
// link, ac and mq registers loaded from the alu or the eae by phase
`timescale 1ns/1ps

module ac_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clear,
    input  pdp8_ac_pkg::phase_t phase,
    input  logic                alu_link,
    input  logic                eae_link,
    input  pdp8_ac_pkg::word_t  alu_ac,
    input  pdp8_ac_pkg::word_t  alu_mq,
    input  pdp8_ac_pkg::word_t  eae_ac,
    input  pdp8_ac_pkg::word_t  eae_mq,
    output logic                link,
    output pdp8_ac_pkg::word_t  ac,
    output pdp8_ac_pkg::word_t  mq
);
    import pdp8_ac_pkg::*;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            link <= 1'b0;
            ac   <= '0;
            mq   <= '0;
        end
        else if (clear)
        begin
            link <= 1'b0;
            ac   <= '0;
            mq   <= '0;
        end
        else
        begin
            case (phase)
                ph_f1, ph_f2, ph_f3, ph_e2, ph_e3:
                begin
                    link <= alu_link;
                    ac   <= alu_ac;
                    mq   <= alu_mq;
                end
                ph_eae0, ph_eae1:
                begin
                    link <= eae_link;
                    ac   <= eae_ac;
                    mq   <= eae_mq;
                end
                default: ;  // idle holds
            endcase
        end
    end

endmodule

//--- ac_top.sv
// accumulator section top level joining sequencer, alu, eae and registers
`timescale 1ns/1ps

module ac_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               clear,
    input  logic               start,
    input  pdp8_ac_pkg::word_t instruction,
    input  pdp8_ac_pkg::word_t operand,
    output logic               busy,
    output logic               done,
    output logic               link,
    output pdp8_ac_pkg::word_t ac,
    output pdp8_ac_pkg::word_t mq
);
    import pdp8_ac_pkg::*;

    phase_t phase;
    logic   eae_loop;
    logic   alu_link;
    logic   eae_link;
    word_t  alu_ac;
    word_t  alu_mq;
    word_t  eae_ac;
    word_t  eae_mq;

    ac_phase_seq u_seq (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear),
        .start       (start),
        .instruction (instruction),
        .eae_loop    (eae_loop),
        .phase       (phase),
        .busy        (busy),
        .done        (done)
    );

    ac_alu u_alu (
        .phase       (phase),
        .instruction (instruction),
        .operand     (operand),
        .ac          (ac),
        .mq          (mq),
        .link        (link),
        .alu_link    (alu_link),
        .alu_ac      (alu_ac),
        .alu_mq      (alu_mq)
    );

    ac_eae_muldiv u_eae (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear),
        .phase       (phase),
        .instruction (instruction),
        .operand     (operand),
        .ac          (ac),
        .mq          (mq),
        .link        (link),
        .eae_loop    (eae_loop),
        .eae_link    (eae_link),
        .eae_ac      (eae_ac),
        .eae_mq      (eae_mq)
    );

    ac_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear),
        .phase       (phase),
        .alu_link    (alu_link),
        .eae_link    (eae_link),
        .alu_ac      (alu_ac),
        .alu_mq      (alu_mq),
        .eae_ac      (eae_ac),
        .eae_mq      (eae_mq),
        .link        (link),
        .ac          (ac),
        .mq          (mq)
    );

endmodule

//--- ac_props.sv
// bound assertions on result rules, done timing, busy and clear of the accumulator section
`timescale 1ns/1ps

module ac_props (
    input logic               clk,
    input logic               arst_n,
    input logic               clear,
    input logic               start,
    input logic               busy,
    input logic               done,
    input logic               link,
    input pdp8_ac_pkg::word_t instruction,
    input pdp8_ac_pkg::word_t operand,
    input pdp8_ac_pkg::word_t ac,
    input pdp8_ac_pkg::word_t mq
);
    import pdp8_ac_pkg::*;

    int          fail_cnt = 0;  // read by the testbench at the end
    logic        pending;       // accepted instruction still waiting for done
    int          cyc;           // cycles since the accepting edge
    word_t       s_ins;
    logic        s_link;
    logic [11:0] s_ac;
    logic [11:0] s_mq;
    logic [11:0] s_op;
    logic        exp_link;
    logic [11:0] exp_ac;
    logic [11:0] exp_mq;
    int          exp_cyc;

    // architectural result of one instruction from the state seen at start
    function automatic void predict(
        input  word_t       ins,
        input  logic        l,
        input  logic [11:0] a,
        input  logic [11:0] m,
        input  logic [11:0] op,
        output logic        el,
        output logic [11:0] ea,
        output logic [11:0] em,
        output int          cycles
    );
        logic [12:0] x;
        logic [23:0] wide;
        el     = l;
        ea     = a;
        em     = m;
        cycles = 1;  // anything outside the kept set
        wide   = {a, m};
        if ((ins & 12'o7417) == eae_mul_code)
        begin
            {ea, em} = 24'(m) * 24'(op) + 24'(a);
            el       = 1'b0;
            cycles   = 14;
        end
        else if ((ins & 12'o7417) == eae_div_code)
        begin
            if (a < op)
            begin
                em     = 12'(wide / 24'(op));
                ea     = 12'(wide % 24'(op));
                el     = 1'b0;
                cycles = 14;
            end
            else
            begin
                el     = 1'b1;  // divide overflow
                cycles = 2;
            end
        end
        else if (ins[0:2] == 3'd7 && !ins[3])
        begin
            x = {ins[5] ? 1'b0 : l, ins[4] ? 12'd0 : a};
            if (ins[6])
                x[11:0] = ~x[11:0];
            if (ins[7])
                x[12] = ~x[12];
            if (ins[11])
                x = x + 13'd1;
            case (ins[8:10])
                3'b100: x = {x[0], x[12:1]};       // rar
                3'b010: x = {x[11:0], x[12]};      // ral
                3'b101: x = {x[1:0], x[12:2]};     // rtr
                3'b011: x = {x[10:0], x[12:11]};   // rtl
                3'b001: x[11:0] = {x[5:0], x[11:6]};
                default: ;
            endcase
            {el, ea} = x;
            cycles   = 4;
        end
        else if (ins[0:2] == 3'd7 && ins[11])
        begin
            ea = ins[4] ? 12'd0 : a;  // cla first
            if (ins[7])
            begin
                em = ea;  // mql
                ea = 12'd0;
            end
            if (ins[5])
                ea = ea | m;  // mqa takes the mq from before mql
            cycles = 4;
        end
        else if (ins[0:2] == 3'd0)
        begin
            ea     = a & op;
            cycles = 3;
        end
        else if (ins[0:2] == 3'd1)
        begin
            {el, ea} = {l, a} + {1'b0, op};
            cycles   = 3;
        end
        else if (ins[0:2] == 3'd3)
        begin
            ea     = 12'd0;
            cycles = 3;
        end
    endfunction

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pending <= 1'b0;
            cyc     <= 0;
        end
        else if (clear)
            pending <= 1'b0;  // aborted, no done may follow
        else if (start && !busy)
        begin
            pending <= 1'b1;
            cyc     <= 1;
            s_ins   <= instruction;
            s_link  <= link;
            s_ac    <= ac;
            s_mq    <= mq;
            s_op    <= operand;
        end
        else if (done)
            pending <= 1'b0;
        else if (pending)
            cyc <= cyc + 1;
    end

    always_comb
    begin
        predict(s_ins, s_link, s_ac, s_mq, s_op, exp_link, exp_ac, exp_mq, exp_cyc);
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy && !done && !link && ac == '0 && mq == '0)
        else
        begin
            $error("t=%0t state after reset is not idle with zero registers", $time);
            fail_cnt++;
        end

    a_done_time: assert property (@(posedge clk) disable iff (!arst_n)
        pending |-> done == (cyc == exp_cyc))
        else
        begin
            $error("FAIL t=%0t done got %b exp %b", $time, $sampled(done),
                   $sampled(cyc) == exp_cyc);
            fail_cnt++;
        end

    a_stray_done: assert property (@(posedge clk) disable iff (!arst_n) done |-> pending)
        else
        begin
            $error("t=%0t done pulse without an accepted start", $time);
            fail_cnt++;
        end

    a_busy: assert property (@(posedge clk) disable iff (!arst_n) pending |-> busy)
        else
        begin
            $error("FAIL t=%0t busy got %b exp 1", $time, $sampled(busy));
            fail_cnt++;
        end

    a_link: assert property (@(posedge clk) disable iff (!arst_n) done |-> link == exp_link)
        else
        begin
            $error("FAIL t=%0t link got %b exp %b", $time, $sampled(link), exp_link);
            fail_cnt++;
        end

    a_ac: assert property (@(posedge clk) disable iff (!arst_n) done |-> ac == exp_ac)
        else
        begin
            $error("FAIL t=%0t ac got %o exp %o", $time, $sampled(ac), exp_ac);
            fail_cnt++;
        end

    a_mq: assert property (@(posedge clk) disable iff (!arst_n) done |-> mq == exp_mq)
        else
        begin
            $error("FAIL t=%0t mq got %o exp %o", $time, $sampled(mq), exp_mq);
            fail_cnt++;
        end

    a_clear: assert property (@(posedge clk) disable iff (!arst_n)
        clear |=> !busy && !link && ac == '0 && mq == '0)
        else
        begin
            $error("t=%0t clear did not zero the registers and stop the sequencer", $time);
            fail_cnt++;
        end

endmodule

//--- tb_ac_top.sv
// testbench for the accumulator section with clock, reset, LCG stimulus and watchdog
`timescale 1ns/1ps

module tb_ac_top;
    import pdp8_ac_pkg::*;

    localparam int mem_loops = 6;
    localparam int op_loops  = 6;
    localparam int eae_loops = 4;
    localparam int n_grp1    = 14;
    localparam int n_grp3    = 7;
    localparam int n_other   = 4;
    // up to 5 preload runs per checked run, each run at most 17 cycles
    localparam int n_runs = 6 * (3 * mem_loops + (n_grp1 + n_grp3) * op_loops
                                 + 3 * eae_loops + 5 + n_other);
    localparam int test_cycles = 17 * n_runs + 60;

    logic        clk;
    logic        arst_n;
    logic        clear;
    logic        start;
    word_t       instruction;
    word_t       operand;
    logic        busy;
    logic        done;
    logic        link;
    word_t       ac;
    word_t       mq;
    int          errors;
    logic [31:0] lcg_state;

    word_t grp1_ops [n_grp1] = '{12'o7341, 12'o7004, 12'o7010, 12'o7006, 12'o7012,
                                 12'o7002, 12'o7040, 12'o7020, 12'o7001, 12'o7041,
                                 12'o7200, 12'o7100, 12'o7044, 12'o7013};
    word_t grp3_ops [n_grp3] = '{12'o7401, 12'o7421, 12'o7501, 12'o7521, 12'o7601,
                                 12'o7621, 12'o7701};
    word_t other_ops [n_other] = '{12'o2000, 12'o5000, 12'o6000, 12'o7402};

    ac_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear),
        .start       (start),
        .instruction (instruction),
        .operand     (operand),
        .busy        (busy),
        .done        (done),
        .link        (link),
        .ac          (ac),
        .mq          (mq)
    );

    bind ac_top ac_props u_props (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[27:16];  // upper bits have the longer period
    endfunction

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!done)
        begin
            errors++;
            $display("ERROR t=%0t no done within %0d cycles of start", $time, limit);
        end
    endtask

    task automatic run_instr(input word_t ins, input word_t op, input bit extra_start);
        @(posedge clk);
        #1;
        instruction = ins;
        operand     = op;
        start       = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (extra_start)
        begin
            repeat (3) @(posedge clk);
            #1;
            start = 1'b1;  // lands while busy
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        wait_done(20);
    endtask

    task automatic preload(input logic l, input word_t a, input word_t m);
        run_instr(12'o7300, '0, 1'b0);  // cla cll
        run_instr(12'o1000, m, 1'b0);
        run_instr(12'o7421, '0, 1'b0);  // mql
        run_instr(12'o1000, a, 1'b0);
        if (l)
            run_instr(12'o7020, '0, 1'b0);  // cml
    endtask

    task automatic random_preload();
        word_t a;
        word_t m;
        word_t l;
        a = rand_word();
        m = rand_word();
        l = rand_word();
        preload(l[0], a, m);
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        #1;
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear = 1'b0;
    endtask

    task automatic abort_mul();
        random_preload();
        @(posedge clk);
        #1;
        instruction = 12'o7405;
        operand     = rand_word();
        start       = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (4) @(posedge clk);
        pulse_clear();
        repeat (20) @(posedge clk);  // a late done would trip the bound checks
    endtask

    initial
    begin
        repeat (2 * test_cycles) @(posedge clk);
        $display("ERROR t=%0t watchdog expired before the tests ended", $time);
        $display("errors: %0d testbench, %0d assertion", errors, dut.u_props.fail_cnt);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        arst_n      = 1'b0;
        clear       = 1'b0;
        start       = 1'b0;
        instruction = '0;
        operand     = '0;
        errors      = 0;
        lcg_state   = 32'h2754;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int i = 0; i < mem_loops; i++)
        begin
            random_preload();
            run_instr(12'o1000, rand_word(), 1'b0);  // tad
            random_preload();
            run_instr(12'o0000, rand_word(), 1'b0);  // and
            random_preload();
            run_instr(12'o3000, rand_word(), 1'b0);  // dca
        end

        for (int i = 0; i < op_loops; i++)
        begin
            foreach (grp1_ops[j])
            begin
                random_preload();
                run_instr(grp1_ops[j], '0, 1'b0);
            end
            foreach (grp3_ops[j])
            begin
                random_preload();
                run_instr(grp3_ops[j], '0, 1'b0);
            end
        end

        for (int i = 0; i < eae_loops; i++)
        begin
            random_preload();
            run_instr(12'o7405, rand_word(), i == 0);  // first mul also sees a stray start
            preload(1'b1, rand_word() & 12'o3777, rand_word());
            run_instr(12'o7407, rand_word() | 12'o4000, 1'b0);  // ac below divisor
            preload(1'b0, rand_word() | 12'o4000, rand_word());
            run_instr(12'o7407, rand_word() & 12'o3777, 1'b0);  // overflow
        end
        random_preload();
        run_instr(12'o7407, '0, 1'b0);  // divide by zero overflows

        foreach (other_ops[j])
        begin
            random_preload();
            run_instr(other_ops[j], rand_word(), 1'b0);
        end

        preload(1'b1, rand_word() | 12'o0001, rand_word() | 12'o0001);
        pulse_clear();  // idle clear with link and registers set
        abort_mul();
        random_preload();
        run_instr(12'o7341, '0, 1'b0);  // sequencer usable after the abort

        repeat (2) @(posedge clk);
        $display("errors: %0d testbench, %0d assertion", errors, dut.u_props.fail_cnt);
        if (errors == 0 && dut.u_props.fail_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- build.f
pdp8_ac_pkg.sv
ac_phase_seq.sv
ac_alu.sv
ac_eae_muldiv.sv
ac_regs.sv
ac_top.sv
ac_props.sv
tb_ac_top.sv
